// ==== flist.f ====
hdl/serv_pkg.sv
hdl/serv_counter.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_immdec.sv
hdl/serv_alu.sv
hdl/serv_ctrl.sv
hdl/serv_rf_if.sv
hdl/serv_top.sv
+incdir+dv
dv/serv_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module serv_tb -o serv_sim
./obj_dir/serv_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
grep -q "TEST PASSED" sim.log

// ==== dv/serv_tb_tests.svh ====
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// Outputs stay quiet for the whole reset
task automatic reset_test();
   for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check(32'(ibus_cyc), 32'd0, "fetch request in reset");
      check(32'(wen0), 32'd0, "write enable in reset");
      check(32'(rf_rreq), 32'd0, "read request in reset");
   end
   @(posedge clk);
   rst_n <= 1'b1;
   wait_fetch();
   check(ibus_adr, RESET_PC, "first fetch address");
endtask

task automatic reg_op_test();
   logic [2:0] f3s [0:4];
   f3s = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR};
   for (int i = 0; i < 5; i++) begin
      run_one(enc_r((i == 1) ? 7'b0100000 : 7'd0, 5'(rand_bits(5)), 5'(rand_bits(5)),
                    f3s[i], 5'(rand_bits(4)) + 5'd1));
   end
endtask

task automatic imm_op_test();
   logic [2:0]  f3s [0:3];
   logic [11:0] imm;
   f3s = '{F3_ADD_SUB, F3_AND, F3_OR, F3_XOR};
   for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 2; s++) begin
         imm = {s[0], 11'(rand_bits(11))};
         run_one(enc_i(imm, 5'(rand_bits(5)), f3s[i], 5'(rand_bits(4)) + 5'd1,
                       OPC_OP_IMM));
      end
   end
   run_one({20'hfedcb, 5'd9, OPC_LUI});
   run_one({20'h12345, 5'd10, OPC_LUI});
endtask

task automatic x0_and_nop_test();
   run_one(enc_r(7'd0, 5'd3, 5'd4, F3_ADD_SUB, 5'd0));
   run_one(enc_i(12'h7ff, 5'd2, F3_OR, 5'd0, OPC_OP_IMM));
   // Load opcode is not kept
   run_one(enc_i(12'h010, 5'd1, 3'b010, 5'd12, 7'b0000011));
endtask

task automatic branch_test();
   rf_model[6] = 32'h8000_1234;
   rf_model[7] = 32'h8000_1234;
   rf_model[8] = 32'h8000_1235;
   run_one(enc_b(13'd16, 5'd7, 5'd6, F3_BEQ));
   run_one(enc_b(13'd8, 5'd8, 5'd6, F3_BEQ));
   run_one(enc_b(13'h1ff8, 5'd8, 5'd6, F3_BNE));
   run_one(enc_b(13'd24, 5'd7, 5'd6, F3_BNE));
   run_one(enc_b(13'd12, 5'd0, 5'd0, F3_BEQ));
endtask

task automatic jal_test();
   run_one(enc_j(21'd40, 5'd1));
   run_one(enc_j(21'h1ffff4, 5'(rand_bits(4)) + 5'd1));
   run_one(enc_j(21'd1024, 5'd0));
   run_one(enc_j(21'd8, 5'd31));
endtask

// ==== dv/serv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_tb
   import serv_pkg::*;
();

   logic             clk = 1'b0;
   logic             rst_n;
   logic [XLEN-1:0]  ibus_rdt;
   logic             ibus_ack;
   logic             rf_ready;
   logic             rdata0;
   logic             rdata1;
   logic [XLEN-1:0]  ibus_adr;
   logic             ibus_cyc;
   logic             rf_rreq;
   logic [REG_W-1:0] rreg0;
   logic [REG_W-1:0] rreg1;
   logic [REG_W-1:0] wreg0;
   logic             wen0;
   logic             wdata0;

   logic [XLEN-1:0]  imem [0:255];
   logic [XLEN-1:0]  rf_model [0:31];
   logic [31:0]      lfsr_r = 32'd83190;
   logic [XLEN-1:0]  pc_exp;

   always #5 clk = ~clk;

   serv_top u_dut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_rreq  (rf_rreq),
      .i_rf_ready (rf_ready),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_wreg0    (wreg0),
      .o_wen0     (wen0),
      .o_wdata0   (wdata0)
   );

   // Taps 32, 22, 2, 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timed out waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // Waits at the falling edge until the fetch request is up
   task automatic wait_fetch();
      int t;
      t = 0;
      @(negedge clk);
      while (!ibus_cyc) begin
         t++;
         if (t > 200) timeout_fail("an instruction fetch");
         check(32'(wen0), 32'd0, "write enable outside the run pass");
         @(negedge clk);
      end
   endtask

   task automatic serve_fetch(output logic [XLEN-1:0] adr);
      int dly;
      wait_fetch();
      adr = ibus_adr;
      dly = int'(rand_bits(2));
      for (int i = 0; i < dly; i++) begin
         @(negedge clk);
         check(32'(ibus_cyc), 32'd1, "fetch request during stall");
         check(ibus_adr, adr, "fetch address during stall");
      end
      @(posedge clk);
      ibus_ack <= 1'b1;
      ibus_rdt <= imem[adr[9:2]];
      @(posedge clk);
      ibus_ack <= 1'b0;
   endtask

   // Reference rules of the kept instructions
   task automatic expect_result(input logic [31:0] ins, input logic [31:0] pc,
                                input logic [31:0] a, input logic [31:0] b,
                                output logic wr, output logic [31:0] val,
                                output logic [31:0] next_pc);
      logic [31:0] imm_i;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic [31:0] op_b;
      logic [2:0]  f3;
      logic        alu_ok;
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      f3 = ins[14:12];
      alu_ok = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
      wr = 1'b0;
      val = '0;
      next_pc = pc + 32'd4;
      op_b = (ins[6:0] == OPC_OP) ? b : imm_i;
      if ((ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM) && alu_ok) begin
         wr = 1'b1;
         case (f3)
            3'b100:  val = a ^ op_b;
            3'b110:  val = a | op_b;
            3'b111:  val = a & op_b;
            default: val = (ins[6:0] == OPC_OP && ins[30]) ? a - op_b : a + op_b;
         endcase
      end else if (ins[6:0] == OPC_LUI) begin
         wr = 1'b1;
         val = {ins[31:12], 12'd0};
      end else if (ins[6:0] == OPC_JAL) begin
         wr = 1'b1;
         val = pc + 32'd4;
         next_pc = pc + imm_j;
      end else if (ins[6:0] == OPC_BRANCH && (f3 == 3'b000 || f3 == 3'b001)) begin
         if ((a == b) ^ f3[0]) next_pc = pc + imm_b;
      end
      if (ins[11:7] == 5'd0) wr = 1'b0;
   endtask

   task automatic run_one(input logic [31:0] ins);
      logic [31:0] adr;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] got;
      logic [31:0] exp_val;
      logic [31:0] exp_pc;
      logic        exp_wr;
      int          t;
      int          dly;
      int          nw;
      imem[pc_exp[9:2]] = ins;
      serve_fetch(adr);
      check(adr, pc_exp, "fetch address");
      t = 0;
      @(negedge clk);
      while (!rf_rreq) begin
         t++;
         if (t > 20) timeout_fail("the register read request");
         @(negedge clk);
      end
      check(32'(rreg0), 32'(ins[19:15]), "rs1 address");
      check(32'(rreg1), 32'(ins[24:20]), "rs2 address");
      a = rf_model[ins[19:15]];
      b = rf_model[ins[24:20]];
      dly = int'(rand_bits(2));
      for (int i = 0; i < dly; i++) begin
         @(posedge clk);
      end
      @(posedge clk);
      rf_ready <= 1'b1;
      @(posedge clk);
      rf_ready <= 1'b0;
      rdata0   <= a[0];
      rdata1   <= b[0];
      got = '0;
      nw = 0;
      for (int k = 0; k < 32; k++) begin
         @(negedge clk);
         if (wen0) begin
            nw++;
            got[k] = wdata0;
            check(32'(wreg0), 32'(ins[11:7]), "write address");
         end
         if (k < 31) begin
            @(posedge clk);
            rdata0 <= a[k+1];
            rdata1 <= b[k+1];
         end
      end
      wait_fetch();
      expect_result(ins, pc_exp, a, b, exp_wr, exp_val, exp_pc);
      check(32'(nw), exp_wr ? 32'd32 : 32'd0, "write enable cycles");
      if (exp_wr) begin
         check(got, exp_val, "rd write data");
         rf_model[ins[11:7]] = got;
      end
      check(ibus_adr, exp_pc, "next fetch address");
      pc_exp = exp_pc;
   endtask

   `include "serv_tb_tests.svh"

   initial begin
      rst_n    = 1'b0;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      rf_ready = 1'b0;
      rdata0   = 1'b0;
      rdata1   = 1'b0;
      pc_exp   = RESET_PC;
      rf_model[0] = '0;
      for (int i = 1; i < 32; i++) begin
         rf_model[i] = rand_bits(32);
      end
      reset_test();
      reg_op_test();
      imm_op_test();
      x0_and_nop_test();
      branch_test();
      jal_test();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/serv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_top
   import serv_pkg::*;
(
   input  wire logic             clk,
   input  wire logic             i_rst_n,
   output logic [XLEN-1:0]       o_ibus_adr,
   output logic                  o_ibus_cyc,
   input  wire logic [XLEN-1:0]  i_ibus_rdt,
   input  wire logic             i_ibus_ack,
   output logic                  o_rf_rreq,
   input  wire logic             i_rf_ready,
   output logic [REG_W-1:0]      o_rreg0,
   output logic [REG_W-1:0]      o_rreg1,
   input  wire logic             i_rdata0,
   input  wire logic             i_rdata1,
   output logic [REG_W-1:0]      o_wreg0,
   output logic                  o_wen0,
   output logic                  o_wdata0
);

   logic [REG_W-1:0] rd_addr;
   logic [REG_W-1:0] rs1_addr;
   logic [REG_W-1:0] rs2_addr;
   logic             rd_write;
   logic             op_b_imm;
   logic             alu_sub;
   logic [1:0]       bool_op;
   logic [1:0]       rd_sel;
   logic             two_stage;
   logic             bne;
   logic             jal;
   logic [1:0]       imm_fmt;

   logic             cnt_en;
   logic             cnt0;
   logic             cnt2;
   logic             cnt_done;
   logic             rd_en;
   logic             pc_en;
   logic             branch_taken;

   logic             imm;
   logic             rs1;
   logic             op_b;
   logic             alu_rd;
   logic             alu_cmp;
   logic             ctrl_rd;

   serv_state u_state (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_ibus_ack     (i_ibus_ack),
      .i_rf_ready     (i_rf_ready),
      .i_cnt_done     (cnt_done),
      .i_two_stage    (two_stage),
      .i_bne          (bne),
      .i_jal          (jal),
      .i_alu_cmp      (alu_cmp),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_rf_rreq      (o_rf_rreq),
      .o_cnt_en       (cnt_en),
      .o_rd_en        (rd_en),
      .o_pc_en        (pc_en),
      .o_branch_taken (branch_taken)
   );

   serv_counter u_counter (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt2     (cnt2),
      .o_cnt_done (cnt_done)
   );

   serv_decode u_decode (
      .clk         (clk),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_ibus_ack  (i_ibus_ack),
      .o_rd_addr   (rd_addr),
      .o_rs1_addr  (rs1_addr),
      .o_rs2_addr  (rs2_addr),
      .o_rd_write  (rd_write),
      .o_op_b_imm  (op_b_imm),
      .o_alu_sub   (alu_sub),
      .o_bool_op   (bool_op),
      .o_rd_sel    (rd_sel),
      .o_two_stage (two_stage),
      .o_bne       (bne),
      .o_jal       (jal),
      .o_imm_fmt   (imm_fmt)
   );

   serv_immdec u_immdec (
      .clk        (clk),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_imm_fmt  (imm_fmt),
      .i_cnt_en   (cnt_en),
      .o_imm      (imm)
   );

   serv_alu u_alu (
      .clk       (clk),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_rs1     (rs1),
      .i_op_b    (op_b),
      .i_sub     (alu_sub),
      .i_bool_op (bool_op),
      .o_alu_rd  (alu_rd),
      .o_alu_cmp (alu_cmp)
   );

   serv_ctrl u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt2     (cnt2),
      .i_pc_en    (pc_en),
      .i_jump     (branch_taken),
      .i_imm      (imm),
      .o_ibus_adr (o_ibus_adr),
      .o_ctrl_rd  (ctrl_rd)
   );

   serv_rf_if u_rf_if (
      .i_rd_en    (rd_en),
      .i_rd_write (rd_write),
      .i_rd_addr  (rd_addr),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_sel   (rd_sel),
      .i_op_b_imm (op_b_imm),
      .i_alu_rd   (alu_rd),
      .i_ctrl_rd  (ctrl_rd),
      .i_imm      (imm),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0),
      .o_rs1      (rs1),
      .o_rs2      (),
      .o_op_b     (op_b)
   );

endmodule

`default_nettype wire

// ==== hdl/serv_rf_if.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_rf_if
   import serv_pkg::*;
(
   input  wire logic             i_rd_en,
   input  wire logic             i_rd_write,
   input  wire logic [REG_W-1:0] i_rd_addr,
   input  wire logic [REG_W-1:0] i_rs1_addr,
   input  wire logic [REG_W-1:0] i_rs2_addr,
   input  wire logic [1:0]       i_rd_sel,
   input  wire logic             i_op_b_imm,
   input  wire logic             i_alu_rd,
   input  wire logic             i_ctrl_rd,
   input  wire logic             i_imm,
   input  wire logic             i_rdata0,
   input  wire logic             i_rdata1,
   output logic [REG_W-1:0]      o_rreg0,
   output logic [REG_W-1:0]      o_rreg1,
   output logic [REG_W-1:0]      o_wreg0,
   output logic                  o_wen0,
   output logic                  o_wdata0,
   output logic                  o_rs1,
   output logic                  o_rs2,
   output logic                  o_op_b
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg0 = i_rd_addr;

   // x0 is never written
   assign o_wen0 = i_rd_en & i_rd_write & (|i_rd_addr);

   always_comb begin
      case (i_rd_sel)
         RD_CTRL: o_wdata0 = i_ctrl_rd;
         RD_IMM:  o_wdata0 = i_imm;
         default: o_wdata0 = i_alu_rd;
      endcase
   end

   assign o_rs1  = i_rdata0;
   assign o_rs2  = i_rdata1;
   assign o_op_b = i_op_b_imm ? i_imm : i_rdata1;

endmodule

`default_nettype wire

// ==== hdl/serv_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_ctrl
   import serv_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_rst_n,
   input  wire logic       i_cnt_en,
   input  wire logic       i_cnt2,
   input  wire logic       i_pc_en,
   input  wire logic       i_jump,
   input  wire logic       i_imm,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ctrl_rd
);

   logic [XLEN-1:0] pc_r;
   logic            shift_en;
   logic            inc_bit;
   logic            inc_carry_r;
   logic            imm_carry_r;
   logic            pc_plus_inc;
   logic            pc_plus_imm;
   logic            new_pc;

   assign shift_en = i_cnt_en & i_pc_en;

   // Only bit 2 of the step is set
   assign inc_bit = i_cnt2 & PC_INC[2];

   assign pc_plus_inc = pc_r[0] ^ inc_bit ^ inc_carry_r;
   assign pc_plus_imm = pc_r[0] ^ i_imm ^ imm_carry_r;

   assign new_pc = i_jump ? pc_plus_imm : pc_plus_inc;

   // Carries stay clear outside the PC pass, so each pass starts at zero
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_r        <= RESET_PC;
         inc_carry_r <= 1'b0;
         imm_carry_r <= 1'b0;
      end else begin
         inc_carry_r <= shift_en & ((pc_r[0] & inc_bit) | (pc_r[0] & inc_carry_r) |
                                    (inc_bit & inc_carry_r));
         imm_carry_r <= shift_en & ((pc_r[0] & i_imm) | (pc_r[0] & imm_carry_r) |
                                    (i_imm & imm_carry_r));
         if (shift_en) begin
            pc_r <= {new_pc, pc_r[XLEN-1:1]};
         end
      end
   end

   assign o_ibus_adr = pc_r;
   assign o_ctrl_rd  = pc_plus_inc;

endmodule

`default_nettype wire

// ==== hdl/serv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_alu
   import serv_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_cnt_en,
   input  wire logic       i_cnt0,
   input  wire logic       i_rs1,
   input  wire logic       i_op_b,
   input  wire logic       i_sub,
   input  wire logic [1:0] i_bool_op,
   output logic            o_alu_rd,
   output logic            o_alu_cmp
);

   logic carry_r;
   logic eq_r;
   logic b_eff;
   logic carry_in;
   logic sum;
   logic bit_eq;
   logic eq_in;

   // Subtract as rs1 + ~b with a carry-in of 1 on bit 0
   assign b_eff    = i_op_b ^ i_sub;
   assign carry_in = i_cnt0 ? i_sub : carry_r;
   assign sum      = i_rs1 ^ b_eff ^ carry_in;

   assign bit_eq = ~(i_rs1 ^ i_op_b);
   assign eq_in  = i_cnt0 | eq_r;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= (i_rs1 & b_eff) | (i_rs1 & carry_in) | (b_eff & carry_in);
         eq_r    <= eq_in & bit_eq;
      end
   end

   // Full-word equality once bit 31 is on the inputs
   assign o_alu_cmp = eq_in & bit_eq;

   always_comb begin
      case (i_bool_op)
         BOOL_XOR: o_alu_rd = i_rs1 ^ i_op_b;
         BOOL_OR:  o_alu_rd = i_rs1 | i_op_b;
         BOOL_AND: o_alu_rd = i_rs1 & i_op_b;
         default:  o_alu_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/serv_immdec.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_immdec
   import serv_pkg::*;
(
   input  wire logic       clk,
   input  wire instr_u     i_ibus_rdt,
   input  wire logic       i_ibus_ack,
   input  wire logic [1:0] i_imm_fmt,
   input  wire logic       i_cnt_en,
   output logic            o_imm
);

   logic [XLEN-1:0] w;
   logic [XLEN-1:0] imm_load;
   logic [XLEN-1:0] imm_r;

   assign w = i_ibus_rdt;

   always_comb begin
      case (i_imm_fmt)
         IMM_U: imm_load = {w[31:12], 12'd0};
         IMM_B: imm_load = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         IMM_J: imm_load = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default: begin
            imm_load = {{20{i_ibus_rdt.i.imm12[11]}}, i_ibus_rdt.i.imm12};
         end
      endcase
   end

   // Rotates rather than shifts, so a second pass sees the same bits
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_r <= imm_load;
      end else if (i_cnt_en) begin
         imm_r <= {imm_r[0], imm_r[XLEN-1:1]};
      end
   end

   assign o_imm = imm_r[0];

endmodule

`default_nettype wire

// ==== hdl/serv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_decode
   import serv_pkg::*;
(
   input  wire logic        clk,
   input  wire instr_u      i_ibus_rdt,
   input  wire logic        i_ibus_ack,
   output logic [REG_W-1:0] o_rd_addr,
   output logic [REG_W-1:0] o_rs1_addr,
   output logic [REG_W-1:0] o_rs2_addr,
   output logic             o_rd_write,
   output logic             o_op_b_imm,
   output logic             o_alu_sub,
   output logic [1:0]       o_bool_op,
   output logic [1:0]       o_rd_sel,
   output logic             o_two_stage,
   output logic             o_bne,
   output logic             o_jal,
   output logic [1:0]       o_imm_fmt
);

   instr_u     instr_r;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       f3_alu_ok;
   logic       is_op;
   logic       is_op_imm;
   logic       is_lui;
   logic       is_branch;
   logic       is_jal;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr_r <= i_ibus_rdt;
      end
   end

   assign opcode = instr_r.r.opcode;
   assign funct3 = instr_r.r.funct3;

   // Other funct3 codes retire as a no-op
   assign f3_alu_ok = (funct3 == F3_ADD_SUB) | (funct3 == F3_XOR) |
                      (funct3 == F3_OR) | (funct3 == F3_AND);

   assign is_op     = (opcode == OPC_OP) & f3_alu_ok;
   assign is_op_imm = (opcode == OPC_OP_IMM) & f3_alu_ok;
   assign is_lui    = (opcode == OPC_LUI);
   assign is_branch = (opcode == OPC_BRANCH) & ((funct3 == F3_BEQ) | (funct3 == F3_BNE));
   assign is_jal    = (opcode == OPC_JAL);

   assign o_rd_addr  = instr_r.r.rd;
   assign o_rs1_addr = instr_r.r.rs1;
   assign o_rs2_addr = instr_r.r.rs2;

   assign o_rd_write  = is_op | is_op_imm | is_lui | is_jal;
   assign o_op_b_imm  = is_op_imm;
   assign o_alu_sub   = is_op & (funct3 == F3_ADD_SUB) & instr_r.r.funct7[5];
   assign o_two_stage = is_branch;
   assign o_bne       = (funct3 == F3_BNE);
   assign o_jal       = is_jal;

   always_comb begin
      case (funct3)
         F3_XOR:  o_bool_op = BOOL_XOR;
         F3_OR:   o_bool_op = BOOL_OR;
         F3_AND:  o_bool_op = BOOL_AND;
         default: o_bool_op = BOOL_ADD;
      endcase
   end

   assign o_rd_sel = is_jal ? RD_CTRL : (is_lui ? RD_IMM : RD_ALU);

   // Taken from the incoming word so the immediate loads in the ack cycle
   always_comb begin
      case (i_ibus_rdt.r.opcode)
         OPC_LUI:    o_imm_fmt = IMM_U;
         OPC_BRANCH: o_imm_fmt = IMM_B;
         OPC_JAL:    o_imm_fmt = IMM_J;
         default:    o_imm_fmt = IMM_I;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/serv_state.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_state
   import serv_pkg::*;
(
   input  wire logic clk,
   input  wire logic i_rst_n,
   input  wire logic i_ibus_ack,
   input  wire logic i_rf_ready,
   input  wire logic i_cnt_done,
   input  wire logic i_two_stage,
   input  wire logic i_bne,
   input  wire logic i_jal,
   input  wire logic i_alu_cmp,
   output logic      o_ibus_cyc,
   output logic      o_rf_rreq,
   output logic      o_cnt_en,
   output logic      o_rd_en,
   output logic      o_pc_en,
   output logic      o_branch_taken
);

   logic [2:0] state_r;
   logic       taken_r;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_r <= ST_IDLE;
         taken_r <= 1'b0;
      end else begin
         case (state_r)
            ST_IDLE:    state_r <= ST_FETCH;
            ST_FETCH:   if (i_ibus_ack) state_r <= ST_DECODE;
            ST_DECODE:  state_r <= ST_RF_WAIT;
            ST_RF_WAIT: if (i_rf_ready) state_r <= ST_RUN;
            ST_RUN: begin
               if (i_cnt_done) begin
                  if (i_two_stage) begin
                     state_r <= ST_RUN2;
                     // BNE inverts the equality result of the compare pass
                     taken_r <= i_alu_cmp ^ i_bne;
                  end else begin
                     state_r <= ST_FETCH;
                  end
               end
            end
            ST_RUN2:    if (i_cnt_done) state_r <= ST_FETCH;
            default:    state_r <= ST_IDLE;
         endcase
      end
   end

   assign o_ibus_cyc = (state_r == ST_FETCH);
   assign o_rf_rreq  = (state_r == ST_DECODE);
   assign o_cnt_en   = (state_r == ST_RUN) | (state_r == ST_RUN2);
   assign o_rd_en    = (state_r == ST_RUN);

   // PC moves only in the last pass of an instruction
   assign o_pc_en = ((state_r == ST_RUN) & !i_two_stage) | (state_r == ST_RUN2);

   assign o_branch_taken = i_jal | (taken_r & (state_r == ST_RUN2));

endmodule

`default_nettype wire

// ==== hdl/serv_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_counter
   import serv_pkg::*;
(
   input  wire logic clk,
   input  wire logic i_rst_n,
   input  wire logic i_cnt_en,
   output logic      o_cnt0,
   output logic      o_cnt2,
   output logic      o_cnt_done
);

   logic [CNT_W-1:0] cnt_r;

   // Wraps back to zero after bit 31
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cnt_r <= '0;
      end else if (i_cnt_en) begin
         cnt_r <= cnt_r + CNT_W'(1);
      end
   end

   assign o_cnt0     = (cnt_r == CNT_W'(0));
   assign o_cnt2     = (cnt_r == CNT_W'(2));
   assign o_cnt_done = &cnt_r;

endmodule

`default_nettype wire

// ==== hdl/serv_pkg.sv ====
`default_nettype none

package serv_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;
   localparam int REG_W = 5;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;

   localparam logic [XLEN-1:0] PC_INC   = 32'd4;
   localparam logic [XLEN-1:0] RESET_PC = 32'd0;

   // Sequencer states
   localparam logic [2:0] ST_IDLE    = 3'd0;
   localparam logic [2:0] ST_FETCH   = 3'd1;
   localparam logic [2:0] ST_DECODE  = 3'd2;
   localparam logic [2:0] ST_RF_WAIT = 3'd3;
   localparam logic [2:0] ST_RUN     = 3'd4;
   localparam logic [2:0] ST_RUN2    = 3'd5;

   // Immediate layouts
   localparam logic [1:0] IMM_I = 2'd0;
   localparam logic [1:0] IMM_U = 2'd1;
   localparam logic [1:0] IMM_B = 2'd2;
   localparam logic [1:0] IMM_J = 2'd3;

   // ALU result taken from the adder or a boolean op
   localparam logic [1:0] BOOL_ADD = 2'd0;
   localparam logic [1:0] BOOL_XOR = 2'd1;
   localparam logic [1:0] BOOL_OR  = 2'd2;
   localparam logic [1:0] BOOL_AND = 2'd3;

   // Source of the rd bit
   localparam logic [1:0] RD_ALU  = 2'd0;
   localparam logic [1:0] RD_CTRL = 2'd1;
   localparam logic [1:0] RD_IMM  = 2'd2;

   typedef union packed {
      struct packed {
         logic [6:0]       funct7;
         logic [REG_W-1:0] rs2;
         logic [REG_W-1:0] rs1;
         logic [2:0]       funct3;
         logic [REG_W-1:0] rd;
         logic [6:0]       opcode;
      } r;
      struct packed {
         logic [11:0]      imm12;
         logic [REG_W-1:0] rs1;
         logic [2:0]       funct3;
         logic [REG_W-1:0] rd;
         logic [6:0]       opcode;
      } i;
   } instr_u;

endpackage

`default_nettype wire
